// File: filelist.f
source/map_pkg.sv
source/map_ctrl.sv
source/mem_decode.sv
source/snd_pulse.sv
source/dac_ds.sv
source/map_nsf_top.sv
tests/map_nsf_properties.sv
tests/map_nsf_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module map_nsf_tb -f filelist.f -o map_nsf_sim

./obj_dir/map_nsf_sim | tee sim.log

if grep -q -F '*** PASSED ***' sim.log; then
	echo "Simulation passed."
else
	echo "Simulation failed, see sim.log."
	exit 1
fi

// File: source/dac_ds.sv
`timescale 1ns/1ps

module dac_ds
#(
	parameter int DEPTH = map_pkg::SND_DEPTH
)
(
	input logic clk,
	input logic map_rst,
	input logic [DEPTH-1:0] vol,
	input map_pkg::master_vol_t master_vol,
	output logic snd
);

	logic [DEPTH+7:0] prod;
	logic [DEPTH-1:0] vol_sc;
	logic [DEPTH-1:0] vol_st;
	logic [DEPTH+1:0] delta;
	logic [DEPTH+1:0] sigma;
	logic [DEPTH+1:0] sigma_st;

	// Master volume, 128 is unity.
	assign prod = (DEPTH+8)'(vol) * (DEPTH+8)'(master_vol);
	assign vol_sc = prod[DEPTH+7] ? {DEPTH{1'b1}} : prod[DEPTH+6:7]; // Saturate.

	always_ff @(posedge clk)
	begin
		vol_st <= vol_sc;
	end

	// Top bit set feeds back -2^DEPTH.
	assign delta = {2'b00, vol_st} + {sigma_st[DEPTH+1], sigma_st[DEPTH+1], {DEPTH{1'b0}}};
	assign sigma = delta + sigma_st;

	always_ff @(posedge clk)
	begin
		if (map_rst)
		begin
			sigma_st <= '0;
			snd <= 1'b0;
		end
		else
		begin
			sigma_st <= sigma;
			snd <= sigma_st[DEPTH+1]; // One-bit output stream.
		end
	end

endmodule

// File: source/map_ctrl.sv
`timescale 1ns/1ps

module map_ctrl
(
	input logic clk,
	input logic map_rst,
	input map_pkg::cpu_bus_t cpu,
	input map_pkg::ss_bus_t ss,
	output map_pkg::map_regs_t regs,
	output logic snd_en,
	output map_pkg::cpu_dat_t ss_rdat
);

	map_pkg::bank_t [7:0] bank;
	map_pkg::bank_t [1:0] bank_fds;
	logic mode;
	logic [7:0] exp_setup;

	logic ss_wr_bank;
	logic cpu_wr_bank;

	assign ss_wr_bank = ss.we & (ss.addr[7:3] == 5'd0);
	assign cpu_wr_bank = cpu.wr & (cpu.addr[15:3] == map_pkg::ADDR_BANK_BASE[15:3]);

	// Banks, FDS banks and player mode.
	always_ff @(posedge clk)
	begin
		if (ss.act)
		begin
			if (ss_wr_bank)
				bank[ss.addr[2:0]] <= ss.dat;
			if (ss.we & (ss.addr == map_pkg::SS_IDX_FDS0))
				bank_fds[0] <= ss.dat;
			if (ss.we & (ss.addr == map_pkg::SS_IDX_FDS1))
				bank_fds[1] <= ss.dat;
			if (ss.we & (ss.addr == map_pkg::SS_IDX_MODE))
				mode <= ss.dat[0];
		end
		else if (map_rst)
		begin
			bank[7] <= map_pkg::RST_BANK7; // Boot from the last bank.
			bank_fds[0] <= map_pkg::RST_FDS0;
			bank_fds[1] <= map_pkg::RST_FDS1;
			mode <= map_pkg::RST_MODE;
		end
		else if (cpu.wr)
		begin
			if (cpu.addr == map_pkg::ADDR_MODE_ON)
				mode <= 1'b0;
			if (cpu.addr == map_pkg::ADDR_MODE_OFF)
				mode <= 1'b1;
			if (cpu.addr == map_pkg::ADDR_FDS0)
				bank_fds[0] <= cpu.dat;
			if (cpu.addr == map_pkg::ADDR_FDS1)
				bank_fds[1] <= cpu.dat;
			if (cpu_wr_bank)
				bank[cpu.addr[2:0]] <= cpu.dat;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Save-state read-back
	always_comb
	begin
		ss_rdat = 8'hFF; // Unused indices.
		if (ss.addr[7:3] == 5'd0)
			ss_rdat = bank[ss.addr[2:0]];
		else if (ss.addr == map_pkg::SS_IDX_FDS0)
			ss_rdat = bank_fds[0];
		else if (ss.addr == map_pkg::SS_IDX_FDS1)
			ss_rdat = bank_fds[1];
		else if (ss.addr == map_pkg::SS_IDX_MODE)
			ss_rdat = {7'd0, mode};
		else if (ss.addr == map_pkg::SS_IDX_EXP)
			ss_rdat = exp_setup;
		else if (ss.addr == map_pkg::SS_IDX_MAP)
			ss_rdat = map_pkg::MAP_IDX; // Lets the menu identify the mapper.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Expansion-sound setup
	// The NSF header picks the chips once, so a reset keeps them.
	always_ff @(posedge clk)
	begin
		if (ss.act)
		begin
			if (ss.we & (ss.addr == map_pkg::SS_IDX_EXP))
				exp_setup <= ss.dat;
		end
		else if (cpu.wr & (cpu.addr == map_pkg::ADDR_EXP))
		begin
			exp_setup <= cpu.dat;
		end
	end

	assign snd_en = exp_setup[map_pkg::EXP_BIT_VRC6]; // Only VRC6 pulse is built.

	assign regs = '{
		bank: bank,
		bank_fds: bank_fds,
		mode: mode,
		exp_setup: exp_setup
	};

endmodule

// File: source/map_nsf_top.sv
`timescale 1ns/1ps

module map_nsf_top
(
	input logic clk,
	input logic map_rst,
	input map_pkg::cpu_bus_t cpu,
	input map_pkg::ss_bus_t ss,
	input map_pkg::ppu_bus_t ppu,
	input logic cpu_rw,
	input map_pkg::sys_cfg_t sys_cfg,
	input map_pkg::master_vol_t master_vol,
	output map_pkg::prg_addr_t prg_addr,
	output logic rom_ce,
	output logic rom_we,
	output logic prg_oe,
	output logic [12:0] chr_addr,
	output logic chr_ce,
	output logic chr_we,
	output logic ciram_a10,
	output logic ciram_ce,
	output map_pkg::cpu_dat_t ss_rdat,
	output logic pwm
);

	map_pkg::map_regs_t regs;
	logic snd_en;
	map_pkg::snd_vol_t snd_vol;

	map_ctrl map_ctrl_inst (
		.clk(clk),
		.map_rst(map_rst),
		.cpu(cpu),
		.ss(ss),
		.regs(regs),
		.snd_en(snd_en),
		.ss_rdat(ss_rdat)
	);

	mem_decode mem_decode_inst (
		.regs(regs),
		.cpu_addr(cpu.addr),
		.cpu_rw(cpu_rw),
		.ppu(ppu),
		.sys_cfg(sys_cfg),
		.prg_addr(prg_addr),
		.rom_ce(rom_ce),
		.rom_we(rom_we),
		.prg_oe(prg_oe),
		.chr_addr(chr_addr),
		.chr_ce(chr_ce),
		.chr_we(chr_we),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce)
	);

	snd_pulse snd_pulse_inst (
		.clk(clk),
		.map_rst(map_rst),
		.cpu(cpu),
		.snd_en(snd_en),
		.snd_vol(snd_vol)
	);

	dac_ds #(.DEPTH(map_pkg::SND_DEPTH)) dac_ds_inst (
		.clk(clk),
		.map_rst(map_rst),
		.vol(snd_vol),
		.master_vol(master_vol),
		.snd(pwm)
	);

endmodule

// File: source/map_pkg.sv
package map_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths
	localparam int SND_DEPTH = 7; // Bits per sound sample.

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_dat_t;
	typedef logic [7:0] bank_t; // 4 KB bank number.
	typedef logic [20:0] prg_addr_t; // Flash byte address.
	typedef logic [7:0] ss_addr_t;
	typedef logic [SND_DEPTH-1:0] snd_vol_t;
	typedef logic [7:0] master_vol_t; // 128 is unity gain.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CPU register addresses
	localparam cpu_addr_t ADDR_BANK_BASE = 16'h5000; // $5000-$5007.
	localparam cpu_addr_t ADDR_FDS0 = 16'h5FF6;
	localparam cpu_addr_t ADDR_FDS1 = 16'h5FF7;
	localparam cpu_addr_t ADDR_MODE_ON = 16'h42FE; // Player mode on, mode = 0.
	localparam cpu_addr_t ADDR_MODE_OFF = 16'h42FF;
	localparam cpu_addr_t ADDR_EXP = 16'h42FC;
	localparam cpu_addr_t ADDR_PULSE_BASE = 16'h9000; // $9000-$9002.

	// Save-state register indices.
	localparam ss_addr_t SS_IDX_FDS0 = 8'd8;
	localparam ss_addr_t SS_IDX_FDS1 = 8'd9;
	localparam ss_addr_t SS_IDX_MODE = 8'd10;
	localparam ss_addr_t SS_IDX_EXP = 8'd11;
	localparam ss_addr_t SS_IDX_MAP = 8'd127;
	localparam cpu_dat_t MAP_IDX = 8'd31; // Mapper number.

	// Reset values.
	localparam bank_t RST_BANK7 = 8'hFF;
	localparam bank_t RST_FDS0 = 8'd6;
	localparam bank_t RST_FDS1 = 8'd7;
	localparam logic RST_MODE = 1'b1;

	// Fixed banks for the special windows.
	localparam bank_t BANK_PLAYER = 8'hFF; // Player code at $F000.
	localparam bank_t BANK_PLA = 8'h08; // $4200 player RAM.
	localparam bank_t BANK_MMC5 = 8'h10; // $5C00 MMC5 ExRAM.

	// Expansion-sound enable bits in exp_setup.
	localparam int EXP_BIT_VRC6 = 0;
	localparam int EXP_BIT_FDS = 2;
	localparam int EXP_BIT_MMC5 = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Buses
	typedef struct packed {
		cpu_addr_t addr;
		cpu_dat_t dat;
		logic wr; // One-cycle write strobe.
	} cpu_bus_t;

	typedef struct packed {
		logic act; // Save-state access in progress.
		logic we; // One-cycle write strobe.
		ss_addr_t addr;
		cpu_dat_t dat;
	} ss_bus_t;

	typedef struct packed {
		bank_t [7:0] bank;
		bank_t [1:0] bank_fds;
		logic mode;
		logic [7:0] exp_setup;
	} map_regs_t;

	typedef struct packed {
		logic mir_v; // Vertical mirroring.
		logic chr_ram; // CHR is RAM, not ROM.
	} sys_cfg_t;

	typedef struct packed {
		logic [13:0] addr;
		logic we;
	} ppu_bus_t;

endpackage

// File: source/mem_decode.sv
`timescale 1ns/1ps

module mem_decode
(
	input map_pkg::map_regs_t regs,
	input map_pkg::cpu_addr_t cpu_addr,
	input logic cpu_rw,
	input map_pkg::ppu_bus_t ppu,
	input map_pkg::sys_cfg_t sys_cfg,
	output map_pkg::prg_addr_t prg_addr,
	output logic rom_ce,
	output logic rom_we,
	output logic prg_oe,
	output logic [12:0] chr_addr,
	output logic chr_ce,
	output logic chr_we,
	output logic ciram_a10,
	output logic ciram_ce
);

	logic act_fds;
	logic act_mmc5;
	logic ram_std; // $6000-$7FFF.
	logic ram_pla; // $4200-$42FF.
	logic ram_mmc5; // $5C00-$5FFF.
	logic ram_x;
	logic ram_fds; // FDS RAM at $8000-$DFFF.
	logic player_bank;

	assign act_fds = regs.exp_setup[map_pkg::EXP_BIT_FDS];
	assign act_mmc5 = regs.exp_setup[map_pkg::EXP_BIT_MMC5];

	assign ram_std = cpu_addr[15:13] == 3'b011;
	assign ram_pla = cpu_addr[15:8] == 8'h42;
	assign ram_mmc5 = (cpu_addr[15:10] == 6'b010111) & act_mmc5;
	assign ram_x = ram_std | ram_pla | ram_mmc5;
	assign ram_fds = cpu_addr[15] & (cpu_addr[15:13] != 3'b111) & act_fds;
	assign player_bank = (cpu_addr[15:12] == 4'hF) & ~regs.mode;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PRG side
	always_comb
	begin
		prg_addr[11:0] = cpu_addr[11:0];
		if (player_bank)
			prg_addr[19:12] = map_pkg::BANK_PLAYER;
		else if (ram_std & act_fds)
			prg_addr[19:12] = regs.bank_fds[cpu_addr[12]];
		else if (ram_std)
			prg_addr[19:12] = {7'd0, cpu_addr[12]};
		else if (ram_pla)
			prg_addr[19:12] = map_pkg::BANK_PLA;
		else if (ram_mmc5)
			prg_addr[19:12] = map_pkg::BANK_MMC5;
		else
			prg_addr[19:12] = regs.bank[cpu_addr[14:12]];
		// FDS maps $6000 into ROM space, the other windows into SRAM.
		prg_addr[20] = (ram_std & act_fds) ? 1'b0 : ram_x;
	end

	assign rom_ce = cpu_addr[15] | ram_x;
	assign rom_we = ~cpu_rw & (ram_x | ram_fds);
	assign prg_oe = cpu_rw;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CHR side
	assign chr_addr = ppu.addr[12:0]; // Flat 8 KB.
	assign ciram_a10 = sys_cfg.mir_v ? ppu.addr[10] : ppu.addr[11];
	assign ciram_ce = ~ppu.addr[13];
	assign chr_ce = ciram_ce;
	assign chr_we = sys_cfg.chr_ram & ppu.we & ciram_ce; // ROM never written.

endmodule

// File: source/snd_pulse.sv
`timescale 1ns/1ps

module snd_pulse
(
	input logic clk,
	input logic map_rst,
	input map_pkg::cpu_bus_t cpu,
	input logic snd_en,
	output map_pkg::snd_vol_t snd_vol
);

	logic wr_hit;
	logic wr_q; // Write pending from the previous cycle.
	logic [1:0] wr_idx;
	map_pkg::cpu_dat_t wr_dat;

	logic [3:0] vol;
	logic [2:0] duty;
	logic dmode; // Constant output, duty ignored.
	logic [7:0] per_lo;
	logic [3:0] per_hi;
	logic pulse_en;

	logic [11:0] period;
	logic [11:0] div;
	logic [3:0] step;

	assign wr_hit = cpu.wr & (cpu.addr[15:2] == map_pkg::ADDR_PULSE_BASE[15:2])
		& (cpu.addr[1:0] != 2'd3);

	always_ff @(posedge clk)
	begin
		if (map_rst)
			wr_q <= 1'b0;
		else
			wr_q <= wr_hit;
		wr_idx <= cpu.addr[1:0];
		wr_dat <= cpu.dat;
	end

	// Channel registers, $9000 to $9002.
	always_ff @(posedge clk)
	begin
		if (map_rst)
		begin
			vol <= '0;
			duty <= '0;
			dmode <= 1'b0;
			per_lo <= '0;
			per_hi <= '0;
			pulse_en <= 1'b0;
		end
		else if (wr_q)
		begin
			case (wr_idx)
				2'd0:
				begin
					vol <= wr_dat[3:0];
					duty <= wr_dat[6:4];
					dmode <= wr_dat[7];
				end
				2'd1: per_lo <= wr_dat;
				default:
				begin
					per_hi <= wr_dat[3:0];
					pulse_en <= wr_dat[7];
				end
			endcase
		end
	end

	assign period = {per_hi, per_lo};

	// Duty sequencer, one step per period+1 clocks.
	always_ff @(posedge clk)
	begin
		if (map_rst | ~pulse_en)
		begin
			div <= period;
			step <= '0; // Disable restarts the duty cycle.
		end
		else if (div == 12'd0)
		begin
			div <= period;
			step <= step + 4'd1;
		end
		else
		begin
			div <= div - 12'd1;
		end
	end

	assign snd_vol = ((dmode | (step <= {1'b0, duty})) & pulse_en & snd_en)
		? map_pkg::snd_vol_t'(vol) : '0;

endmodule

// File: tests/map_nsf_properties.sv
`timescale 1ns/1ps

module map_nsf_properties
(
	input logic clk,
	input logic map_rst,
	input map_pkg::cpu_bus_t cpu,
	input map_pkg::ss_bus_t ss,
	input map_pkg::ppu_bus_t ppu,
	input logic cpu_rw,
	input map_pkg::sys_cfg_t sys_cfg,
	input map_pkg::map_regs_t regs,
	input map_pkg::prg_addr_t prg_addr,
	input logic rom_we,
	input logic chr_we,
	input logic ciram_a10,
	input logic pwm
);

	logic cpu_wr_ok;

	assign cpu_wr_ok = cpu.wr & ~ss.act & ~map_rst; // CPU write that the mapper takes.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register file
	reset_values: assert property (@(posedge clk) map_rst & ~ss.act |=>
		regs.bank[7] == map_pkg::RST_BANK7 && regs.mode == map_pkg::RST_MODE
		&& regs.bank_fds[0] == map_pkg::RST_FDS0 && regs.bank_fds[1] == map_pkg::RST_FDS1)
		else $error("registers did not take their reset values");

	bank_write: assert property (@(posedge clk)
		cpu_wr_ok & (cpu.addr[15:3] == 13'h0A00) |=>
		regs.bank[$past(cpu.addr[2:0])] == $past(cpu.dat))
		else $error("bank write not visible in the next cycle");

	mode_on: assert property (@(posedge clk)
		cpu_wr_ok & (cpu.addr == map_pkg::ADDR_MODE_ON) |=> !regs.mode)
		else $error("player mode did not turn on");

	ss_hold: assert property (@(posedge clk) ss.act & ~ss.we |=> regs == $past(regs))
		else $error("registers changed during save state");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode and sound output
	rom_space: assert property (@(posedge clk) cpu.addr[15] |-> !prg_addr[20])
		else $error("ROM address landed in RAM space");

	no_we_on_read: assert property (@(posedge clk) cpu_rw |-> !rom_we)
		else $error("rom_we high during a CPU read");

	chr_rom_safe: assert property (@(posedge clk) !sys_cfg.chr_ram |-> !chr_we)
		else $error("chr_we high with CHR ROM");

	mirroring: assert property (@(posedge clk)
		ciram_a10 == (sys_cfg.mir_v ? ppu.addr[10] : ppu.addr[11]))
		else $error("ciram_a10 does not follow the mirroring");

	pwm_reset: assert property (@(posedge clk) map_rst |=> !pwm)
		else $error("pwm high after reset");

endmodule

bind map_nsf_top map_nsf_properties map_nsf_properties_inst (.*);

// File: tests/map_nsf_tb.sv
`timescale 1ns/1ps

module map_nsf_tb;

	logic clk = 1'b0;
	logic map_rst;
	map_pkg::cpu_bus_t cpu;
	map_pkg::ss_bus_t ss;
	map_pkg::ppu_bus_t ppu;
	logic cpu_rw;
	map_pkg::sys_cfg_t sys_cfg;
	map_pkg::master_vol_t master_vol;
	map_pkg::prg_addr_t prg_addr;
	logic rom_ce;
	logic rom_we;
	logic prg_oe;
	logic [12:0] chr_addr;
	logic chr_ce;
	logic chr_we;
	logic ciram_a10;
	logic ciram_ce;
	map_pkg::cpu_dat_t ss_rdat;
	logic pwm;

	// Expected register copies.
	logic [7:0] bank_m [8];
	logic [7:0] fds_m [2];
	logic mode_m;
	logic [7:0] exp_m;
	int checks = 0;
	int errs = 0;
	int errs_at = 0; // Error count when the current test began.

	map_nsf_top map_nsf_top_inst (
		.clk(clk),
		.map_rst(map_rst),
		.cpu(cpu),
		.ss(ss),
		.ppu(ppu),
		.cpu_rw(cpu_rw),
		.sys_cfg(sys_cfg),
		.master_vol(master_vol),
		.prg_addr(prg_addr),
		.rom_ce(rom_ce),
		.rom_we(rom_we),
		.prg_oe(prg_oe),
		.chr_addr(chr_addr),
		.chr_ce(chr_ce),
		.chr_we(chr_we),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce),
		.ss_rdat(ss_rdat),
		.pwm(pwm)
	);

	always #4 clk = ~clk;

	initial
	begin
		#200000;
		$display("Watchdog expired, the run did not finish in time.");
		$display("*** FAILED ***");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errs++;
			$display("FAIL %s got %h expected %h", name, got, want);
		end
	endtask

	function automatic void model_write(input logic [15:0] addr, input logic [7:0] dat);
		if (addr >= 16'h5000 && addr <= 16'h5007)
			bank_m[addr[2:0]] = dat;
		if (addr == 16'h5FF6)
			fds_m[0] = dat;
		if (addr == 16'h5FF7)
			fds_m[1] = dat;
		if (addr == 16'h42FE)
			mode_m = 1'b0;
		if (addr == 16'h42FF)
			mode_m = 1'b1;
		if (addr == 16'h42FC)
			exp_m = dat;
	endfunction

	// Expected PRG bank for $6000-$FFFF.
	function automatic logic [7:0] ref_prg_bank(input logic [15:0] addr);
		if (addr[15:12] == 4'hF && !mode_m)
			return 8'hFF; // Player code.
		if (addr[15:13] == 3'b011)
			return exp_m[2] ? fds_m[addr[12]] : {7'd0, addr[12]};
		return bank_m[addr[14:12]];
	endfunction

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] dat);
		@(posedge clk);
		cpu <= '{addr: addr, dat: dat, wr: 1'b1};
		cpu_rw <= 1'b0;
		@(posedge clk);
		cpu.wr <= 1'b0;
		cpu_rw <= 1'b1;
		if (!ss.act)
			model_write(addr, dat); // Mapper ignores the CPU during save state.
	endtask

	task automatic set_cpu_addr(input logic [15:0] addr);
		@(posedge clk);
		cpu.addr <= addr;
		@(negedge clk);
	endtask

	task automatic ss_read(input logic [7:0] idx, input logic [7:0] want);
		@(posedge clk);
		ss.addr <= idx;
		@(negedge clk);
		check($sformatf("ss_rdat[%0d]", idx), 32'(ss_rdat), 32'(want));
	endtask

	task automatic wait_pwm(input logic level, input int limit);
		int n = 0;
		@(negedge clk);
		while (pwm !== level && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (pwm !== level)
		begin
			errs++;
			$display("pwm did not reach %0d within %0d cycles", level, limit);
		end
	endtask

	task automatic end_test(input string name);
		if (errs == errs_at)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errs - errs_at);
		errs_at = errs;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	initial
	begin
		logic [15:0] a;
		logic [7:0] d;
		logic [7:0] ss_m [12];
		int cnt;
		int want_ones;
		void'($urandom(32'h6067));
		map_rst <= 1'b1;
		cpu <= '0;
		ss <= '0;
		ppu <= '0;
		cpu_rw <= 1'b1;
		sys_cfg <= '0;
		master_vol <= 8'd128; // Unity gain.
		repeat (2) @(posedge clk);
		map_rst <= 1'b0;
		mode_m = map_pkg::RST_MODE;

		ss_read(8'd7, 8'hFF);
		ss_read(8'd8, 8'd6);
		ss_read(8'd9, 8'd7);
		ss_read(8'd10, 8'd1);
		ss_read(8'd127, 8'd31);
		check("pwm", 32'(pwm), 32'd0);
		end_test("reset_values");

		for (int i = 0; i < 8; i++)
			cpu_write(16'h5000 | {13'd0, i[2:0]}, 8'($urandom));
		repeat (12)
		begin
			a = {1'b1, 15'($urandom)};
			set_cpu_addr(a);
			check("prg_addr[19:12]", 32'(prg_addr[19:12]), 32'(ref_prg_bank(a)));
			check("prg_addr[20]", 32'(prg_addr[20]), 32'd0);
			check("rom_ce", 32'(rom_ce), 32'd1);
		end
		cpu_write(map_pkg::ADDR_MODE_ON, 8'h00);
		a = {4'hF, 12'($urandom)};
		set_cpu_addr(a);
		check("prg_addr[19:12]", 32'(prg_addr[19:12]), 32'(ref_prg_bank(a))); // Player code bank.
		cpu_write(map_pkg::ADDR_MODE_OFF, 8'h00);
		end_test("bank_switching");

		cpu_write(map_pkg::ADDR_EXP, 8'h00);
		repeat (6)
		begin
			a = {3'b011, 13'($urandom)};
			set_cpu_addr(a);
			check("prg_addr[19:12]", 32'(prg_addr[19:12]), 32'(ref_prg_bank(a)));
			check("prg_addr[20]", 32'(prg_addr[20]), 32'd1);
			check("rom_ce", 32'(rom_ce), 32'd1);
		end
		@(posedge clk);
		cpu_rw <= 1'b0;
		@(negedge clk);
		check("rom_we", 32'(rom_we), 32'd1);
		check("prg_oe", 32'(prg_oe), 32'd0);
		@(posedge clk);
		cpu_rw <= 1'b1;
		@(negedge clk);
		check("rom_we", 32'(rom_we), 32'd0);
		check("prg_oe", 32'(prg_oe), 32'd1);
		set_cpu_addr({2'b00, 14'($urandom)}); // Below every PRG window.
		check("rom_ce", 32'(rom_ce), 32'd0);
		cpu_write(map_pkg::ADDR_FDS0, 8'($urandom));
		cpu_write(map_pkg::ADDR_FDS1, 8'($urandom));
		cpu_write(map_pkg::ADDR_EXP, 8'h04); // FDS RAM enabled.
		for (int i = 0; i < 2; i++)
		begin
			a = {3'b011, i[0], 12'($urandom)};
			set_cpu_addr(a);
			check("prg_addr[19:12]", 32'(prg_addr[19:12]), 32'(ref_prg_bank(a)));
			check("prg_addr[20]", 32'(prg_addr[20]), 32'd0);
		end
		end_test("ram_windows");

		for (int i = 0; i < 12; i++)
		begin
			d = 8'($urandom);
			ss_m[i] = (i == 10) ? {7'd0, d[0]} : d;
			@(posedge clk);
			ss <= '{act: 1'b1, we: 1'b1, addr: 8'(i), dat: d};
		end
		@(posedge clk);
		ss.we <= 1'b0;
		cpu_write(16'h5002, ~ss_m[2]);
		cpu_write(map_pkg::ADDR_FDS0, ~ss_m[8]);
		cpu_write(map_pkg::ADDR_MODE_ON, 8'h00);
		cpu_write(map_pkg::ADDR_EXP, ~ss_m[11]);
		for (int i = 0; i < 12; i++)
			ss_read(8'(i), ss_m[i]);
		ss_read(8'd127, 8'd31);
		ss_read(8'd200, 8'hFF);
		@(posedge clk);
		ss.act <= 1'b0;
		for (int i = 0; i < 8; i++)
			bank_m[i] = ss_m[i];
		fds_m[0] = ss_m[8];
		fds_m[1] = ss_m[9];
		mode_m = ss_m[10][0];
		exp_m = ss_m[11];
		repeat (4)
		begin
			a = {1'b1, 15'($urandom)};
			set_cpu_addr(a);
			check("prg_addr[19:12]", 32'(prg_addr[19:12]), 32'(ref_prg_bank(a)));
		end
		end_test("save_state");

		repeat (24)
		begin
			@(posedge clk);
			ppu <= '{addr: 14'($urandom), we: 1'($urandom)};
			sys_cfg <= '{mir_v: 1'($urandom), chr_ram: 1'($urandom)};
			@(negedge clk);
			check("ciram_a10", 32'(ciram_a10), 32'(sys_cfg.mir_v ? ppu.addr[10] : ppu.addr[11]));
			check("ciram_ce", 32'(ciram_ce), 32'(!ppu.addr[13]));
			check("chr_ce", 32'(chr_ce), 32'(!ppu.addr[13]));
			check("chr_addr", 32'(chr_addr), 32'(ppu.addr[12:0]));
			if (!sys_cfg.chr_ram)
				check("chr_we", 32'(chr_we), 32'd0);
		end
		end_test("mirroring_chr");

		cpu_write(map_pkg::ADDR_EXP, 8'h01); // VRC6 pulse on.
		cpu_write(16'h9002, 8'h80);
		cpu_write(16'h9000, 8'h8C); // Constant level 12.
		wait_pwm(1'b1, 64);
		want_ones = 12 * 1024 / 128;
		cnt = 0;
		repeat (1024)
		begin
			@(negedge clk);
			cnt = cnt + 32'(pwm);
		end
		checks++;
		if (cnt < want_ones - 2 || cnt > want_ones + 2)
		begin
			errs++;
			$display("FAIL pwm_ones got %h expected %h", cnt, want_ones);
		end
		cpu_write(map_pkg::ADDR_EXP, 8'h00);
		repeat (3) @(posedge clk); // DAC latency.
		repeat (64)
		begin
			@(negedge clk);
			check("pwm", 32'(pwm), 32'd0);
		end
		end_test("sound");

		$display("checks: %0d  errors: %0d", checks, errs);
		if (errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
